// File: logic/rw_engine_pkg.sv
// Shared sizes and packet types for the read/write address stage, imported by RTL and testbench
package rw_engine_pkg;

  // ------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------

  // Width of one memory packet field
  localparam int FIELD_WIDTH  = 32;

  // Fields carried by every memory packet
  localparam int NUM_FIELDS   = 4;

  // Base pointer and request address width
  localparam int ADDR_WIDTH   = 64;

  // Granularity shift amount, 0 to 31
  localparam int SHIFT_WIDTH  = 5;

  // Operand field that becomes the address offset
  localparam int OFFSET_FIELD = 1;

  // ------------------------------------------------------------
  // Packet types
  // ------------------------------------------------------------

  // One field word
  typedef logic [FIELD_WIDTH-1:0] packet_field_t;

  // Whole packet, field 0 sits in the low bits
  typedef packet_field_t [NUM_FIELDS-1:0] memory_packet_t;

  // ------------------------------------------------------------
  // Configuration types
  // ------------------------------------------------------------

  // One bit per destination field, set means take the constant
  typedef logic [NUM_FIELDS-1:0] field_mask_t;

  // Row i selects the source fields for destination field i
  // Bit (i, j) set means field j may feed field i
  typedef logic [NUM_FIELDS-1:0][NUM_FIELDS-1:0] route_mask_t;

  // Granularity shift amount
  typedef logic [SHIFT_WIDTH-1:0] shift_amount_t;

  // Byte address and array base pointer
  typedef logic [ADDR_WIDTH-1:0] address_t;

endpackage : rw_engine_pkg

// File: logic/rw_config_regs.sv
// Configuration holding registers, loaded by a strobe and kept valid until a clear or reset
module rw_config_regs (
  input  logic                          ap_clk,
  input  logic                          areset,
  input  logic                          clear,
  input  logic                          config_load,
  input  rw_engine_pkg::field_mask_t    const_mask,
  input  rw_engine_pkg::packet_field_t  const_value,
  input  rw_engine_pkg::route_mask_t    route_mask,
  input  rw_engine_pkg::shift_amount_t  granularity,
  input  logic                          shift_left,
  input  rw_engine_pkg::address_t       array_base,
  input  logic                          write_request,
  output logic                          config_valid,
  output rw_engine_pkg::field_mask_t    held_const_mask,
  output rw_engine_pkg::packet_field_t  held_const_value,
  output rw_engine_pkg::route_mask_t    held_route_mask,
  output rw_engine_pkg::shift_amount_t  held_granularity,
  output logic                          held_shift_left,
  output rw_engine_pkg::address_t       held_array_base,
  output logic                          held_write_request
);

  // ------------------------------------------------------------
  // Valid level
  // ------------------------------------------------------------

  // Clear beats a load arriving on the same edge
  always_ff @(posedge ap_clk) begin
    if (areset || clear) begin
      config_valid <= 1'b0;
    end else if (config_load) begin
      config_valid <= 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Held fields
  // ------------------------------------------------------------

  // Only a load changes these, clear leaves them alone
  // Values show up on the cycle after the strobe
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      held_const_mask    <= '0;
      held_const_value   <= '0;
      held_route_mask    <= '0;
      held_granularity   <= '0;
      held_shift_left    <= 1'b0;
      held_array_base    <= '0;
      held_write_request <= 1'b0;
    end else if (config_load && !clear) begin
      held_const_mask    <= const_mask;
      held_const_value   <= const_value;
      held_route_mask    <= route_mask;
      held_granularity   <= granularity;
      held_shift_left    <= shift_left;
      held_array_base    <= array_base;
      held_write_request <= write_request;
    end
  end

endmodule : rw_config_regs

// File: logic/rw_operand_select.sv
// Operand selection stage, builds a registered operand packet from constants and routed input fields
module rw_operand_select (
  input  logic                          ap_clk,
  input  logic                          areset,
  input  logic                          clear,
  input  logic                          config_valid,
  input  rw_engine_pkg::field_mask_t    const_mask,
  input  rw_engine_pkg::packet_field_t  const_value,
  input  rw_engine_pkg::route_mask_t    route_mask,
  input  logic                          data_valid,
  input  rw_engine_pkg::memory_packet_t data,
  output logic                          operand_valid,
  output rw_engine_pkg::memory_packet_t operand
);

  import rw_engine_pkg::*;

  // Next operand packet before the register
  memory_packet_t operand_next;

  // Packet is taken only under a valid configuration
  logic           accept;

  assign accept = data_valid && config_valid;

  // ------------------------------------------------------------
  // Field selection
  // ------------------------------------------------------------

  always_comb begin
    operand_next = '0;
    for (int i = 0; i < NUM_FIELDS; i++) begin
      if (const_mask[i]) begin
        operand_next[i] = const_value;
      end else begin
        // Ascending scan, so the highest set source is the last write
        // An empty row leaves the field at zero
        for (int j = 0; j < NUM_FIELDS; j++) begin
          if (route_mask[i][j]) begin
            operand_next[i] = data[j];
          end
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Operand register
  // ------------------------------------------------------------

  // Valid follows the accept condition by one cycle
  always_ff @(posedge ap_clk) begin
    if (areset || clear) begin
      operand_valid <= 1'b0;
    end else begin
      operand_valid <= accept;
    end
  end

  // Payload holds its last value between packets
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      operand <= '0;
    end else if (accept) begin
      operand <= operand_next;
    end
  end

endmodule : rw_operand_select

// File: logic/rw_address_gen.sv
// Address stage, shifts operand field 1 onto the array base and registers the request
module rw_address_gen (
  input  logic                          ap_clk,
  input  logic                          areset,
  input  logic                          clear,
  input  rw_engine_pkg::shift_amount_t  granularity,
  input  logic                          shift_left,
  input  rw_engine_pkg::address_t       array_base,
  input  logic                          write_request,
  input  logic                          operand_valid,
  input  rw_engine_pkg::memory_packet_t operand,
  output logic                          request_valid,
  output rw_engine_pkg::address_t       request_address,
  output rw_engine_pkg::memory_packet_t request_data,
  output logic                          request_write
);

  import rw_engine_pkg::*;

  // Configuration the operand stage used, one cycle behind the held copy
  shift_amount_t stage_granularity;
  logic          stage_shift_left;
  address_t      stage_array_base;
  logic          stage_write_request;

  // Offset field zero-extended to full address width
  address_t offset_wide;

  // Offset after the granularity shift
  address_t offset_shifted;

  // Base plus offset, wraps modulo 2^64
  address_t address_next;

  // ------------------------------------------------------------
  // Configuration delay
  // ------------------------------------------------------------

  // A packet entering on a reload strobe keeps the old configuration here too
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      stage_granularity   <= '0;
      stage_shift_left    <= 1'b0;
      stage_array_base    <= '0;
      stage_write_request <= 1'b0;
    end else begin
      stage_granularity   <= granularity;
      stage_shift_left    <= shift_left;
      stage_array_base    <= array_base;
      stage_write_request <= write_request;
    end
  end

  // ------------------------------------------------------------
  // Offset and address
  // ------------------------------------------------------------

  assign offset_wide = {{(ADDR_WIDTH - FIELD_WIDTH){1'b0}}, operand[OFFSET_FIELD]};

  // Left shift scales an index up, right shift scales it down
  always_comb begin
    if (stage_shift_left) begin
      offset_shifted = offset_wide << stage_granularity;
    end else begin
      offset_shifted = offset_wide >> stage_granularity;
    end
  end

  // Carry out of bit 63 is dropped
  assign address_next = stage_array_base + offset_shifted;

  // ------------------------------------------------------------
  // Request register
  // ------------------------------------------------------------

  // Valid and address are both cleared
  always_ff @(posedge ap_clk) begin
    if (areset || clear) begin
      request_valid   <= 1'b0;
      request_address <= '0;
    end else begin
      request_valid <= operand_valid;
      if (operand_valid) begin
        request_address <= address_next;
      end
    end
  end

  // Data and write flag ride along with the address
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      request_data  <= '0;
      request_write <= 1'b0;
    end else if (operand_valid) begin
      request_data  <= operand;
      request_write <= stage_write_request;
    end
  end

endmodule : rw_address_gen

// File: logic/rw_engine_top.sv
// Top of the read/write address stage, wires config registers into operand selection and address forming
module rw_engine_top (
  input  logic                          ap_clk,
  input  logic                          areset,
  input  logic                          clear,
  input  logic                          config_load,
  input  rw_engine_pkg::field_mask_t    const_mask,
  input  rw_engine_pkg::packet_field_t  const_value,
  input  rw_engine_pkg::route_mask_t    route_mask,
  input  rw_engine_pkg::shift_amount_t  granularity,
  input  logic                          shift_left,
  input  rw_engine_pkg::address_t       array_base,
  input  logic                          write_request,
  input  logic                          data_valid,
  input  rw_engine_pkg::memory_packet_t data,
  output logic                          request_valid,
  output rw_engine_pkg::address_t       request_address,
  output rw_engine_pkg::memory_packet_t request_data,
  output logic                          request_write
);

  import rw_engine_pkg::*;

  // ------------------------------------------------------------
  // Held configuration
  // ------------------------------------------------------------

  logic           config_valid;
  field_mask_t    held_const_mask;
  packet_field_t  held_const_value;
  route_mask_t    held_route_mask;
  shift_amount_t  held_granularity;
  logic           held_shift_left;
  address_t       held_array_base;
  logic           held_write_request;

  // Stage 1 to stage 2
  logic           operand_valid;
  memory_packet_t operand;

  rw_config_regs u_rw_config_regs (
    .ap_clk             (ap_clk),
    .areset             (areset),
    .clear              (clear),
    .config_load        (config_load),
    .const_mask         (const_mask),
    .const_value        (const_value),
    .route_mask         (route_mask),
    .granularity        (granularity),
    .shift_left         (shift_left),
    .array_base         (array_base),
    .write_request      (write_request),
    .config_valid       (config_valid),
    .held_const_mask    (held_const_mask),
    .held_const_value   (held_const_value),
    .held_route_mask    (held_route_mask),
    .held_granularity   (held_granularity),
    .held_shift_left    (held_shift_left),
    .held_array_base    (held_array_base),
    .held_write_request (held_write_request)
  );

  // ------------------------------------------------------------
  // Two-stage datapath
  // ------------------------------------------------------------

  // Packets are gated here, later stages trust operand_valid
  rw_operand_select u_rw_operand_select (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .clear         (clear),
    .config_valid  (config_valid),
    .const_mask    (held_const_mask),
    .const_value   (held_const_value),
    .route_mask    (held_route_mask),
    .data_valid    (data_valid),
    .data          (data),
    .operand_valid (operand_valid),
    .operand       (operand)
  );

  rw_address_gen u_rw_address_gen (
    .ap_clk          (ap_clk),
    .areset          (areset),
    .clear           (clear),
    .granularity     (held_granularity),
    .shift_left      (held_shift_left),
    .array_base      (held_array_base),
    .write_request   (held_write_request),
    .operand_valid   (operand_valid),
    .operand         (operand),
    .request_valid   (request_valid),
    .request_address (request_address),
    .request_data    (request_data),
    .request_write   (request_write)
  );

endmodule : rw_engine_top

// File: tb/rw_engine_tb.sv
// Randomized self-checking testbench for the read/write address stage, compiled from the file list
module rw_engine_tb;

  import rw_engine_pkg::*;

  localparam int RAND_SEED      = 29832;
  localparam int PACKETS        = 300;
  localparam int BATCH          = 50;
  // Load, one batch and two idle cycles per configuration, plus the drain
  localparam int RANDOM_CYCLES  = (PACKETS / BATCH) * (BATCH + 3) + 4;
  // Reset, three random tests, gating, clear, streaming, then margin
  localparam int TIMEOUT_CYCLES = 5 + 3 * RANDOM_CYCLES + 40 + 50 + 210 + 200;

  // One expected request, stamped with its due cycle
  typedef struct packed {
    int             due;
    memory_packet_t data;
    address_t       addr;
    logic           write;
  } request_t;

  logic           ap_clk;
  logic           areset;
  logic           clear;
  logic           config_load;
  field_mask_t    const_mask;
  packet_field_t  const_value;
  route_mask_t    route_mask;
  shift_amount_t  granularity;
  logic           shift_left;
  address_t       array_base;
  logic           write_request;
  logic           data_valid;
  memory_packet_t data;
  logic           request_valid;
  address_t       request_address;
  memory_packet_t request_data;
  logic           request_write;

  // Reference model state, owned by the checker
  request_t       expected_q[$];
  logic           model_valid = 1'b0;
  field_mask_t    model_cmask;
  packet_field_t  model_cval;
  route_mask_t    model_rmask;
  shift_amount_t  model_gran;
  logic           model_shl;
  address_t       model_base;
  logic           model_write;
  int             check_count;
  int             error_count;

  // Bookkeeping of the stimulus process
  int             cycle = 0;
  string          test_name = "reset";
  int             checks_at_start;
  int             errors_at_start;
  int             stim_errors;
  int             tests_ok;
  int             tests_bad;

  rw_engine_top u_rw_engine_top (
    .ap_clk          (ap_clk),
    .areset          (areset),
    .clear           (clear),
    .config_load     (config_load),
    .const_mask      (const_mask),
    .const_value     (const_value),
    .route_mask      (route_mask),
    .granularity     (granularity),
    .shift_left      (shift_left),
    .array_base      (array_base),
    .write_request   (write_request),
    .data_valid      (data_valid),
    .data            (data),
    .request_valid   (request_valid),
    .request_address (request_address),
    .request_data    (request_data),
    .request_write   (request_write)
  );

  initial begin
    ap_clk = 1'b0;
    forever #20 ap_clk = ~ap_clk;
  end

  // Watchdog on the cycle count
  always @(posedge ap_clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still busy after %0d cycles", cycle);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------

  // Constant wins, else highest routed source, else zero
  function automatic memory_packet_t expect_operand(memory_packet_t in);
    memory_packet_t result;
    result = '0;
    for (int i = 0; i < NUM_FIELDS; i++) begin
      if (model_cmask[i]) begin
        result[i] = model_cval;
      end else begin
        for (int j = NUM_FIELDS - 1; j >= 0; j--) begin
          if (model_rmask[i][j]) begin
            result[i] = in[j];
            break;
          end
        end
      end
    end
    return result;
  endfunction

  // Zero-extended field 1, shifted, added with wraparound
  function automatic address_t expect_address(memory_packet_t op);
    address_t offset;
    offset = address_t'(op[OFFSET_FIELD]);
    offset = model_shl ? (offset << model_gran) : (offset >> model_gran);
    return model_base + offset;
  endfunction

  // Outputs and inputs are both stable at the falling edge
  always @(negedge ap_clk) begin
    request_t head;
    if (expected_q.size() > 0 && expected_q[0].due == cycle) begin
      head = expected_q.pop_front();
      assert (request_valid) else begin
        $display("Missing request in %s, packet due at cycle %0d", test_name, head.due);
        error_count++;
      end
      if (request_valid) begin
        check_count++;
        assert (request_address == head.addr) else begin
          $display("Mismatch in %s: address expected %h actual %h",
                   test_name, head.addr, request_address);
          error_count++;
        end
        assert (request_data == head.data) else begin
          $display("Mismatch in %s: data expected %h actual %h",
                   test_name, head.data, request_data);
          error_count++;
        end
        assert (request_write == head.write) else begin
          $display("Mismatch in %s: write expected %b actual %b",
                   test_name, head.write, request_write);
          error_count++;
        end
      end
    end else begin
      assert (!request_valid) else begin
        $display("Request in %s at cycle %0d with no packet due", test_name, cycle);
        error_count++;
      end
    end
    // What the next rising edge will sample
    if (areset || clear) begin
      expected_q.delete();
      model_valid = 1'b0;
    end else begin
      // Same-cycle load does not apply to this packet
      if (data_valid && model_valid) begin
        head.due   = cycle + 2;
        head.data  = expect_operand(data);
        head.addr  = expect_address(head.data);
        head.write = model_write;
        expected_q.push_back(head);
      end
      if (config_load) begin
        model_valid = 1'b1;
        model_cmask = const_mask;
        model_cval  = const_value;
        model_rmask = route_mask;
        model_gran  = granularity;
        model_shl   = shift_left;
        model_base  = array_base;
        model_write = write_request;
      end
    end
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------

  // Mode 1 favors routing, mode 2 puts the base near the top and alternates the shift
  task automatic drive_cycle(input bit load, input bit valid, input bit clr, input int mode);
    route_mask_t rm;
    @(posedge ap_clk);
    config_load <= load;
    data_valid  <= valid;
    clear       <= clr;
    data        <= {$urandom, $urandom, $urandom, $urandom};
    if (load) begin
      rm = route_mask_t'($urandom);
      if (mode == 1) begin
        // One empty row per load
        rm[2'($urandom)] = '0;
      end
      const_mask    <= (mode == 1 && $urandom % 2 == 0) ? '0 : field_mask_t'($urandom);
      const_value   <= $urandom;
      route_mask    <= rm;
      granularity   <= shift_amount_t'($urandom);
      shift_left    <= (mode == 2) ? !shift_left : 1'($urandom);
      array_base    <= (mode == 2) ? ~address_t'($urandom % 65536) : {$urandom, $urandom};
      write_request <= 1'($urandom);
    end
  endtask

  task automatic apply_reset();
    areset <= 1'b1;
    repeat (5) drive_cycle(1'b0, 1'b0, 1'b0, 0);
    areset <= 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    checks_at_start = check_count;
    errors_at_start = error_count;
    stim_errors     = 0;
  endtask

  // Waits until every expected request has come out
  task automatic end_test();
    int errors;
    do begin
      drive_cycle(1'b0, 1'b0, 1'b0, 0);
    end while (expected_q.size() != 0);
    drive_cycle(1'b0, 1'b0, 1'b0, 0);
    errors = error_count - errors_at_start + stim_errors;
    if (errors == 0) begin
      tests_ok++;
    end else begin
      tests_bad++;
    end
    $display("Test %s finished: %0d requests checked, %0d errors",
             test_name, check_count - checks_at_start, errors);
  endtask

  // A fresh random configuration for every batch
  task automatic run_random_test(input string name, input int mode);
    start_test(name);
    for (int b = 0; b < PACKETS / BATCH; b++) begin
      drive_cycle(1'b1, 1'b0, 1'b0, mode);
      repeat (BATCH) drive_cycle(1'b0, 1'b1, 1'b0, mode);
      repeat (2) drive_cycle(1'b0, 1'b0, 1'b0, mode);
    end
    end_test();
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    areset        <= 1'b1;
    clear         <= 1'b0;
    config_load   <= 1'b0;
    const_mask    <= '0;
    const_value   <= '0;
    route_mask    <= '0;
    granularity   <= '0;
    shift_left    <= 1'b0;
    array_base    <= '0;
    write_request <= 1'b0;
    data_valid    <= 1'b0;
    data          <= '0;
    apply_reset();

    run_random_test("constant fields", 0);
    run_random_test("field routing", 1);
    run_random_test("address forming", 2);

    // No configuration, then a load with a packet on the same cycle
    start_test("reconfiguration and gating");
    apply_reset();
    repeat (4) drive_cycle(1'b0, 1'b1, 1'b0, 0);
    drive_cycle(1'b1, 1'b1, 1'b0, 0);
    repeat (8) drive_cycle(1'b0, 1'b1, 1'b0, 0);
    // Reload with a packet on the strobe, old packets still in flight
    drive_cycle(1'b1, 1'b1, 1'b0, 2);
    repeat (8) drive_cycle(1'b0, 1'b1, 1'b0, 2);
    end_test();

    start_test("clear");
    drive_cycle(1'b1, 1'b0, 1'b0, 0);
    repeat (20) drive_cycle(1'b0, 1'b1, 1'b0, 0);
    drive_cycle(1'b0, 1'b1, 1'b1, 0);
    repeat (10) drive_cycle(1'b0, 1'b1, 1'b0, 0);
    drive_cycle(1'b1, 1'b0, 1'b0, 0);
    repeat (10) drive_cycle(1'b0, 1'b1, 1'b0, 0);
    end_test();

    // Due stamps hold the exact latency, the queue the order
    start_test("latency and throughput");
    drive_cycle(1'b1, 1'b0, 1'b0, 0);
    repeat (200) drive_cycle(1'b0, 1'b1, 1'b0, 0);
    repeat (3) drive_cycle(1'b0, 1'b0, 1'b0, 0);
    assert (check_count - checks_at_start == 200) else begin
      $display("Streaming gave %0d requests instead of 200", check_count - checks_at_start);
      stim_errors++;
    end
    end_test();

    $display("Summary: %0d tests clean, %0d tests with errors", tests_ok, tests_bad);
    if (tests_bad == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : rw_engine_tb

// File: tb.f
logic/rw_engine_pkg.sv
logic/rw_config_regs.sv
logic/rw_operand_select.sv
logic/rw_address_gen.sv
logic/rw_engine_top.sv
tb/rw_engine_tb.sv

// File: Makefile
# Verilator build and run of the read/write address stage testbench

VERILATOR ?= verilator
FILELIST  ?= tb.f
TOP       ?= rw_engine_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
	  echo "Simulation reported failure, see $(LOG)"; \
	  exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
